// File: source/boot_ctrl_defs.svh
// Sizing and timing constants for the boot and mailbox front end, included by package and RTL
`ifndef BOOT_CTRL_DEFS_SVH
`define BOOT_CTRL_DEFS_SVH

// Obfuscation key size in 32-bit words
`define FUSE_KEY_WORDS 4

// Mailbox SRAM geometry
`define MBOX_DEPTH 32
`define MBOX_AW 5

// Settle period between fuse lock and mailbox ready
`define BOOT_SETTLE_CYCLES 16
`define TIMER_W 8

`endif

// File: source/boot_ctrl_pkg.sv
// Shared types for the boot and mailbox front end; imported by the RTL and the checker
`include "boot_ctrl_defs.svh"

package boot_ctrl_pkg;

    // First mailbox word of a message
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  rsvd;
        logic [15:0] dlen;
    } mbox_hdr_t;

    // Header at address 0, raw data elsewhere
    typedef union packed {
        logic [31:0] raw;
        mbox_hdr_t   hdr;
    } mbox_word_u;

    // SECDED(39,32) storage word, data in the low bits
    typedef struct packed {
        logic        par;
        logic [5:0]  hamming;
        logic [31:0] data;
    } ecc_word_t;

    typedef struct packed {
        logic        wr;
        logic [1:0]  idx;
        logic [31:0] data;
    } fuse_wr_t;

    typedef logic [`FUSE_KEY_WORDS-1:0][31:0] obf_key_t;

    typedef struct packed {
        logic flip_single;
        logic flip_double;
    } ras_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        sb_err;
        logic        db_err;
    } mbox_rsp_t;

    // Sticky until reset
    typedef struct packed {
        logic fuse_late_wr;
        logic ecc_single;
        logic ecc_double;
    } err_status_t;

    typedef enum logic [2:0] {
        IDLE,
        FUSE_WAIT,
        BRKPOINT,
        SETTLE,
        READY
    } boot_state_e;

endpackage

// File: source/boot_fsm.sv
// Boot sequencer; opens the fuse window, honours the breakpoint and enables the mailbox
`timescale 1ns/100ps

module boot_fsm import boot_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pwrgood,
    input  logic        brkpoint,
    input  logic        fuse_done,
    input  logic        timer_expire,
    output logic        timer_start,
    output logic        fuse_open,
    output logic        mbox_en,
    output boot_state_e state
);

    boot_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pwrgood) begin
                    state_next = FUSE_WAIT;
                end
            end
            FUSE_WAIT: begin
                // Breakpoint is sampled as the fuse window closes
                if (fuse_done) begin
                    state_next = brkpoint ? BRKPOINT : SETTLE;
                end
            end
            BRKPOINT: begin
                if (!brkpoint) begin
                    state_next = SETTLE;
                end
            end
            SETTLE: begin
                if (timer_expire) begin
                    state_next = READY;
                end
            end
            READY: begin
                state_next = READY;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Timer loads on the edge that enters SETTLE
    assign timer_start = (state_next == SETTLE) && (state != SETTLE);

    assign fuse_open = (state == FUSE_WAIT);
    assign mbox_en   = (state == READY);

endmodule

// File: source/boot_timer.sv
// Loadable down-counter that times the settle period before the mailbox opens
`timescale 1ns/100ps
`include "boot_ctrl_defs.svh"

module boot_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic expire
);

    logic [`TIMER_W-1:0] cnt;
    logic                running;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (start) begin
            // Last cycle of the period is the one where cnt reads zero
            cnt     <= `TIMER_W'(`BOOT_SETTLE_CYCLES - 1);
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign expire = running && (cnt == '0);

endmodule

// File: source/fuse_bank.sv
// Obfuscation key registers written during the fuse window and locked once it closes
`timescale 1ns/100ps

module fuse_bank import boot_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     fuse_open,
    input  fuse_wr_t fuse_wr,
    output obf_key_t obf_key,
    output logic     late_wr
);

    // Set once the window has opened, so a closed window means locked
    logic was_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            was_open <= 1'b0;
        end else if (fuse_open) begin
            was_open <= 1'b1;
        end
    end

    // Key is cleared on reset so no stale secret survives
    always_ff @(posedge clk) begin
        if (rst) begin
            obf_key <= '0;
        end else if (fuse_open && fuse_wr.wr) begin
            obf_key[fuse_wr.idx] <= fuse_wr.data;
        end
    end

    // Writes before the window opens are simply dropped
    assign late_wr = fuse_wr.wr && was_open && !fuse_open;

endmodule

// File: source/mbox_ctrl.sv
// Mailbox write pointer, header capture, data-available flag and ECC word storage
`timescale 1ns/100ps
`include "boot_ctrl_defs.svh"

module mbox_ctrl import boot_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               mbox_en,
    input  logic               mbox_wr,
    input  mbox_word_u         mbox_wdata,
    input  logic               mbox_rd,
    input  logic [`MBOX_AW-1:0] mbox_raddr,
    input  logic               mbox_release,
    input  ecc_word_t          enc_word,
    output logic [31:0]        store_data,
    output ecc_word_t          stored_word,
    output mbox_hdr_t          mbox_cmd,
    output logic               data_avail,
    output logic               rd_valid
);

    ecc_word_t           mem [`MBOX_DEPTH];
    logic [`MBOX_AW-1:0] wr_ptr;
    logic                wr_accept;
    logic                last_word;

    // Full mailbox ignores writes until released
    assign wr_accept = mbox_en && mbox_wr && !data_avail;

    assign store_data = mbox_wdata.raw;

    // Message is complete once dlen data words follow the header
    always_comb begin
        if (wr_ptr == '0) begin
            last_word = (mbox_wdata.hdr.dlen == '0);
        end else begin
            last_word = (16'(wr_ptr) == mbox_cmd.dlen);
        end
        // Oversized length stops at the end of the array
        if (wr_ptr == `MBOX_AW'(`MBOX_DEPTH - 1)) begin
            last_word = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            data_avail <= 1'b0;
            mbox_cmd   <= '0;
        end else if (mbox_release) begin
            wr_ptr     <= '0;
            data_avail <= 1'b0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_ptr == '0) begin
                mbox_cmd <= mbox_wdata.hdr;
            end
            if (last_word) begin
                data_avail <= 1'b1;
            end
        end
    end

    // SRAM array holds the encoded word
    always_ff @(posedge clk) begin
        if (wr_accept && !mbox_release) begin
            mem[wr_ptr] <= enc_word;
        end
    end

    always_ff @(posedge clk) begin
        if (mbox_rd) begin
            stored_word <= mem[mbox_raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mbox_rd;
        end
    end

endmodule

// File: source/mbox_ecc.sv
// SECDED(39,32) encode with RAS bit flips on writes, check and correct on mailbox reads
`timescale 1ns/100ps

module mbox_ecc import boot_ctrl_pkg::*; (
    input  logic [31:0] wr_data,
    input  ras_ctrl_t   ras_ctrl,
    output ecc_word_t   enc_word,
    input  ecc_word_t   stored_word,
    input  logic        rd_valid,
    output mbox_rsp_t   mbox_rsp
);

    // Data bits sit at the non power of two positions 3..38
    function automatic logic [5:0] hamming_of(logic [31:0] d);
        logic [5:0]  p;
        int unsigned j;
        p = '0;
        j = 0;
        for (int unsigned pos = 1; pos < 39; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (d[j]) begin
                    p = p ^ 6'(pos);
                end
                j++;
            end
        end
        return p;
    endfunction

    function automatic logic [31:0] correct(logic [31:0] d, logic [5:0] syn);
        logic [31:0] c;
        int unsigned j;
        c = d;
        j = 0;
        for (int unsigned pos = 1; pos < 39; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (6'(pos) == syn) begin
                    c[j] = ~c[j];
                end
                j++;
            end
        end
        return c;
    endfunction

    ecc_word_t  code;
    logic [1:0] flip;
    logic [5:0] syndrome;
    logic       par_err;
    logic       single_err;
    logic       double_err;

    always_comb begin
        code.data    = wr_data;
        code.hamming = hamming_of(wr_data);
        code.par     = ^{code.hamming, wr_data};
    end

    // Double flip wins over single
    assign flip     = ras_ctrl.flip_double ? 2'b11 : {1'b0, ras_ctrl.flip_single};
    assign enc_word = code ^ {{($bits(ecc_word_t) - 2){1'b0}}, flip};

    assign syndrome   = hamming_of(stored_word.data) ^ stored_word.hamming;
    assign par_err    = ^stored_word;
    // Odd parity means one flipped bit, even with a syndrome means two
    assign single_err = par_err;
    assign double_err = !par_err && (syndrome != '0);

    always_comb begin
        mbox_rsp.valid  = rd_valid;
        mbox_rsp.data   = single_err ? correct(stored_word.data, syndrome) : stored_word.data;
        mbox_rsp.sb_err = rd_valid && single_err;
        mbox_rsp.db_err = rd_valid && double_err;
    end

endmodule

// File: source/boot_ctrl_top.sv
// Top of the boot and mailbox front end; connects the blocks and keeps the error status
`timescale 1ns/100ps
`include "boot_ctrl_defs.svh"

module boot_ctrl_top import boot_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                pwrgood,
    input  logic                brkpoint,
    input  fuse_wr_t            fuse_wr,
    input  logic                fuse_done,
    input  logic                mbox_wr,
    input  mbox_word_u          mbox_wdata,
    input  logic                mbox_rd,
    input  logic [`MBOX_AW-1:0] mbox_raddr,
    input  logic                mbox_release,
    input  ras_ctrl_t           ras_ctrl,
    output logic                ready_for_fuses,
    output logic                ready_for_mb_processing,
    output logic                mailbox_data_avail,
    output obf_key_t            obf_key,
    output mbox_hdr_t           mbox_cmd,
    output mbox_rsp_t           mbox_rsp,
    output err_status_t         err_status,
    output logic                error_fatal,
    output logic                error_non_fatal
);

    logic        timer_start;
    logic        timer_expire;
    logic        late_wr;
    logic        rd_valid;
    logic [31:0] store_data;
    ecc_word_t   enc_word;
    ecc_word_t   stored_word;
    boot_state_e boot_state;

    boot_fsm boot_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .pwrgood      (pwrgood),
        .brkpoint     (brkpoint),
        .fuse_done    (fuse_done),
        .timer_expire (timer_expire),
        .timer_start  (timer_start),
        .fuse_open    (ready_for_fuses),
        .mbox_en      (ready_for_mb_processing),
        .state        (boot_state)
    );

    boot_timer boot_timer_inst (
        .clk    (clk),
        .rst    (rst),
        .start  (timer_start),
        .expire (timer_expire)
    );

    fuse_bank fuse_bank_inst (
        .clk       (clk),
        .rst       (rst),
        .fuse_open (ready_for_fuses),
        .fuse_wr   (fuse_wr),
        .obf_key   (obf_key),
        .late_wr   (late_wr)
    );

    mbox_ctrl mbox_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .mbox_en      (ready_for_mb_processing),
        .mbox_wr      (mbox_wr),
        .mbox_wdata   (mbox_wdata),
        .mbox_rd      (mbox_rd),
        .mbox_raddr   (mbox_raddr),
        .mbox_release (mbox_release),
        .enc_word     (enc_word),
        .store_data   (store_data),
        .stored_word  (stored_word),
        .mbox_cmd     (mbox_cmd),
        .data_avail   (mailbox_data_avail),
        .rd_valid     (rd_valid)
    );

    mbox_ecc mbox_ecc_inst (
        .wr_data     (store_data),
        .ras_ctrl    (ras_ctrl),
        .enc_word    (enc_word),
        .stored_word (stored_word),
        .rd_valid    (rd_valid),
        .mbox_rsp    (mbox_rsp)
    );

    // Error bits stay set until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            err_status <= '0;
        end else begin
            err_status.fuse_late_wr <= err_status.fuse_late_wr | late_wr;
            err_status.ecc_single   <= err_status.ecc_single | mbox_rsp.sb_err;
            err_status.ecc_double   <= err_status.ecc_double | mbox_rsp.db_err;
        end
    end

    assign error_fatal     = err_status.ecc_double;
    assign error_non_fatal = err_status.fuse_late_wr | err_status.ecc_single;

endmodule

// File: testbench/boot_ctrl_checker.sv
// Concurrent timing and flag rules for the boot and mailbox front end, bound into the top level
`timescale 1ns/100ps

module boot_ctrl_checker import boot_ctrl_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        ready_for_fuses,
    input logic        ready_for_mb_processing,
    input logic        mailbox_data_avail,
    input logic        mbox_rd,
    input mbox_rsp_t   mbox_rsp,
    input err_status_t err_status,
    input boot_state_e state
);

    // Failure count, read by the testbench at the end of the run
    int assert_errors = 0;

    ready_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ready_for_fuses && ready_for_mb_processing))
        else begin
            $error("ready_for_fuses and ready_for_mb_processing high together");
            assert_errors++;
        end

    // Mailbox only serves in READY
    avail_needs_ready: assert property (@(posedge clk) disable iff (rst)
        mailbox_data_avail |-> (ready_for_mb_processing && state == READY))
        else begin
            $error("mailbox_data_avail high outside READY");
            assert_errors++;
        end

    rsp_after_rd: assert property (@(posedge clk) disable iff (rst)
        mbox_rd |=> mbox_rsp.valid)
        else begin
            $error("mbox_rsp.valid missing one cycle after mbox_rd");
            assert_errors++;
        end

    no_rsp_without_rd: assert property (@(posedge clk) disable iff (rst)
        !mbox_rd |=> !mbox_rsp.valid)
        else begin
            $error("mbox_rsp.valid without a read one cycle before");
            assert_errors++;
        end

    flags_after_rst: assert property (@(posedge clk)
        rst |=> (state == IDLE && !ready_for_fuses && !ready_for_mb_processing
                 && !mailbox_data_avail && !mbox_rsp.valid && err_status == '0))
        else begin
            $error("flags not cleared in the cycle after rst");
            assert_errors++;
        end

endmodule

bind boot_ctrl_top boot_ctrl_checker boot_ctrl_checker_inst (
    .clk                     (clk),
    .rst                     (rst),
    .ready_for_fuses         (ready_for_fuses),
    .ready_for_mb_processing (ready_for_mb_processing),
    .mailbox_data_avail      (mailbox_data_avail),
    .mbox_rd                 (mbox_rd),
    .mbox_rsp                (mbox_rsp),
    .err_status              (err_status),
    .state                   (boot_state)
);

// File: testbench/boot_ctrl_tb.sv
// Testbench for the boot and mailbox front end; runs the operations listed in the vectors file
`timescale 1ns/100ps
`include "boot_ctrl_defs.svh"

module boot_ctrl_tb import boot_ctrl_pkg::*; ();

    logic                core_clk;
    logic                rst;
    logic                pwrgood;
    logic                brkpoint;
    fuse_wr_t            fuse_wr;
    logic                fuse_done;
    logic                mbox_wr;
    mbox_word_u          mbox_wdata;
    logic                mbox_rd;
    logic [`MBOX_AW-1:0] mbox_raddr;
    logic                mbox_release;
    ras_ctrl_t           ras_ctrl;
    logic                ready_for_fuses;
    logic                ready_for_mb_processing;
    logic                mailbox_data_avail;
    obf_key_t            obf_key;
    mbox_hdr_t           mbox_cmd;
    mbox_rsp_t           mbox_rsp;
    err_status_t         err_status;
    logic                error_fatal;
    logic                error_non_fatal;

    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 100000;
    int          hold_cycles = 0;
    logic [31:0] lfsr = 32'h75fcfdb5;
    string       vecs[$];

    boot_ctrl_top boot_ctrl_top_inst (.clk(core_clk), .*);

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Galois form, taps for x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // Inputs change 1 ns after the edge, outputs are stable there
    task automatic next_cycle();
        @(posedge core_clk);
        #1;
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_key(input obf_key_t exp);
        if (obf_key !== exp) begin
            $display("Fail at %0t ns: obf_key is %h, expected %h", $time, obf_key, exp);
            errors++;
        end
    endtask

    task automatic check_hdr(input mbox_hdr_t exp);
        if (mbox_cmd !== exp) begin
            $display("Fail at %0t ns: mbox_cmd is %h, expected %h", $time, mbox_cmd, exp);
            errors++;
        end
    endtask

    task automatic check_err(input err_status_t exp);
        if (err_status !== exp) begin
            $display("Fail at %0t ns: err_status is %b, expected %b", $time, err_status, exp);
            errors++;
        end
    endtask

    task automatic check_rsp(input mbox_rsp_t exp, input logic data_care);
        if (mbox_rsp.valid !== exp.valid || mbox_rsp.sb_err !== exp.sb_err
                || mbox_rsp.db_err !== exp.db_err
                || (data_care && mbox_rsp.data !== exp.data)) begin
            $display("Fail at %0t ns: mbox_rsp is v%b %h sb%b db%b, expected v%b %h sb%b db%b",
                     $time, mbox_rsp.valid, mbox_rsp.data, mbox_rsp.sb_err, mbox_rsp.db_err,
                     exp.valid, exp.data, exp.sb_err, exp.db_err);
            errors++;
        end
    endtask

    task automatic load_vectors(output logic ok);
        int    fd;
        string line;
        fd = $fopen("testbench/boot_ctrl_vectors.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    vecs.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic reset_and_power_up();
        repeat (10) @(posedge core_clk);
        #1;
        rst = 1'b0;
        check_flag("ready_for_fuses", ready_for_fuses, 1'b0);
        check_flag("mailbox_data_avail", mailbox_data_avail, 1'b0);
        check_err('0);
        pwrgood = 1'b1;
        next_cycle();
        check_flag("ready_for_fuses", ready_for_fuses, 1'b1);
    endtask

    task automatic fuse_write(input logic [1:0] idx, input logic [31:0] data);
        fuse_wr.wr = 1'b1;
        fuse_wr.idx = idx;
        fuse_wr.data = data;
        next_cycle();
        fuse_wr = '0;
    endtask

    task automatic fuse_close();
        fuse_done = 1'b1;
        next_cycle();
        fuse_done = 1'b0;
        check_flag("ready_for_fuses", ready_for_fuses, 1'b0);
        // Mailbox must stay closed for the whole breakpoint hold
        repeat (hold_cycles) begin
            next_cycle();
            check_flag("ready_for_mb_processing", ready_for_mb_processing, 1'b0);
        end
        brkpoint = 1'b0;
        hold_cycles = 0;
        while (!ready_for_mb_processing) begin
            next_cycle();
        end
    endtask

    task automatic mbox_write(input logic [31:0] data, input logic [1:0] inject);
        logic [1:0] gap;
        take_bit(gap[0]);
        take_bit(gap[1]);
        repeat (gap) next_cycle();
        mbox_wr = 1'b1;
        mbox_wdata.raw = data;
        ras_ctrl.flip_single = (inject == 2'd1);
        ras_ctrl.flip_double = (inject == 2'd2);
        next_cycle();
        mbox_wr = 1'b0;
        ras_ctrl = '0;
    endtask

    task automatic mbox_read(input logic [`MBOX_AW-1:0] addr, input logic [31:0] data,
                             input logic sb, input logic db);
        mbox_rsp_t exp;
        exp.valid = 1'b1;
        exp.data = data;
        exp.sb_err = sb;
        exp.db_err = db;
        mbox_rd = 1'b1;
        mbox_raddr = addr;
        next_cycle();
        mbox_rd = 1'b0;
        // Data is undefined after a double-bit error
        check_rsp(exp, !db);
    endtask

    task automatic mbox_free();
        mbox_release = 1'b1;
        next_cycle();
        mbox_release = 1'b0;
    endtask

    task automatic run_vector(input string vec);
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        obf_key_t    exp_key;
        mbox_hdr_t   exp_hdr;
        err_status_t exp_err;
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        void'($sscanf(vec, "%s %h %h %h %h", op, a, b, c, d));
        case (op)
            "F": fuse_write(a[1:0], b);
            "B": begin
                brkpoint = 1'b1;
                // Hold outlasts the settle period so an ignored breakpoint would show
                hold_cycles = a + `BOOT_SETTLE_CYCLES;
            end
            "D": fuse_close();
            "W": mbox_write(a, b[1:0]);
            "R": mbox_read(a[`MBOX_AW-1:0], b, c[0], d[0]);
            "L": mbox_free();
            "K": begin
                exp_key = {d, c, b, a};
                check_key(exp_key);
            end
            "H": begin
                exp_hdr.opcode = a[7:0];
                exp_hdr.rsvd = 8'h00;
                exp_hdr.dlen = b[15:0];
                check_hdr(exp_hdr);
            end
            "A": check_flag("mailbox_data_avail", mailbox_data_avail, a[0]);
            "E": begin
                exp_err.fuse_late_wr = a[0];
                exp_err.ecc_single = b[0];
                exp_err.ecc_double = c[0];
                // Status registers the response flags one cycle later
                next_cycle();
                check_err(exp_err);
                check_flag("error_fatal", error_fatal, c[0]);
                check_flag("error_non_fatal", error_non_fatal, a[0] | b[0]);
            end
            default: begin
                $display("Unknown operation in vectors file: %s", vec);
                errors++;
            end
        endcase
    endtask

    initial begin
        logic loaded;
        int   chk_errs;
        rst = 1'b1;
        pwrgood = 1'b0;
        brkpoint = 1'b0;
        fuse_wr = '0;
        fuse_done = 1'b0;
        mbox_wr = 1'b0;
        mbox_wdata = '0;
        mbox_rd = 1'b0;
        mbox_raddr = '0;
        mbox_release = 1'b0;
        ras_ctrl = '0;
        load_vectors(loaded);
        if (!loaded) begin
            $display("Could not open testbench/boot_ctrl_vectors.txt for reading");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            cycle_limit = vecs.size() * 64 + `BOOT_SETTLE_CYCLES + 200;
            reset_and_power_up();
            foreach (vecs[i]) begin
                run_vector(vecs[i]);
            end
            repeat (2) next_cycle();
            chk_errs = boot_ctrl_top_inst.boot_ctrl_checker_inst.assert_errors;
            $display("Errors: %0d check mismatches, %0d assertion failures", errors, chk_errs);
            if (errors == 0 && chk_errs == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

// File: testbench/boot_ctrl_vectors.txt
# op and up to four hex fields: F idx data | B hold | D | W data inject(1 single, 2 double)
# R addr data sb db | L | K key0..key3 | H opcode dlen | A avail | E late single double
F 0 a5a5f00d
F 1 1234abcd
F 2 0badcafe
F 3 deadbeef
K a5a5f00d 1234abcd 0badcafe deadbeef
B 6
D
F 1 ffffffff
K a5a5f00d 1234abcd 0badcafe deadbeef
E 1 0 0
W 3c000003 0
H 3c 3
W 11111111 0
W 22222222 0
A 0
W 33333333 0
A 1
R 0 3c000003 0 0
R 1 11111111 0 0
R 2 22222222 0 0
R 3 33333333 0 0
E 1 0 0
L
A 0
W 5a000002 0
H 5a 2
W 0f0f0f0f 1
A 0
W 76543210 2
A 1
W 44444444 0
W 55555555 0
A 1
R 3 33333333 0 0
R 0 5a000002 0 0
R 1 0f0f0f0f 1 0
E 1 1 0
R 2 0 0 1
E 1 1 1
L
A 0

// File: build.f
+incdir+source
source/boot_ctrl_pkg.sv
source/boot_fsm.sv
source/boot_timer.sv
source/fuse_bank.sv
source/mbox_ctrl.sv
source/mbox_ecc.sv
source/boot_ctrl_top.sv
testbench/boot_ctrl_checker.sv
testbench/boot_ctrl_tb.sv

// File: Bender.yml
package:
  name: boot_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/boot_ctrl_pkg.sv
      - source/boot_fsm.sv
      - source/boot_timer.sv
      - source/fuse_bank.sv
      - source/mbox_ctrl.sv
      - source/mbox_ecc.sv
      - source/boot_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/boot_ctrl_checker.sv
      - testbench/boot_ctrl_tb.sv
